// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f tb.f --top-module tb_top -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hw/alu.sv
/*
 * RV32I ALU: add, sub, shifts, set-less-than and logic ops,
 * with zero and signed/unsigned less-than flags for branches
 */
`timescale 1ns/1ps
`include "rv_defs.svh"

module alu (
  input  logic [`RV_XLEN-1:0] a,
  input  logic [`RV_XLEN-1:0] b,
  input  rv_pkg::alu_op_e     op,
  output logic [`RV_XLEN-1:0] y,
  output logic                zero,
  output logic                lt,
  output logic                ltu
);

  logic [4:0] shamt;

  // Only the low five bits shift on RV32
  assign shamt = b[4:0];

  // Comparisons straight from the operands
  assign lt  = $signed(a) < $signed(b);
  assign ltu = a < b;

  always_comb begin
    case (op)
      rv_pkg::ALU_ADD: begin
        y = a + b;
      end
      rv_pkg::ALU_SUB: begin
        y = a - b;
      end
      rv_pkg::ALU_SLL: begin
        y = a << shamt;
      end
      rv_pkg::ALU_SLT: begin
        y = {{(`RV_XLEN-1){1'b0}}, lt};
      end
      rv_pkg::ALU_SLTU: begin
        y = {{(`RV_XLEN-1){1'b0}}, ltu};
      end
      rv_pkg::ALU_XOR: begin
        y = a ^ b;
      end
      rv_pkg::ALU_SRL: begin
        y = a >> shamt;
      end
      rv_pkg::ALU_SRA: begin
        y = $unsigned($signed(a) >>> shamt);
      end
      rv_pkg::ALU_OR: begin
        y = a | b;
      end
      rv_pkg::ALU_AND: begin
        y = a & b;
      end
      default: begin
        y = a + b;
      end
    endcase
  end

  // Equal operands give zero on sub, used by BEQ and BNE
  assign zero = (y == '0);

endmodule

// File: hw/control_unit.sv
/*
 * RV32I multicycle control: fetch/decode/execute/memory/writeback FSM,
 * instruction decode and APB master sequencing
 */
`timescale 1ns/1ps
`include "rv_defs.svh"

module control_unit (
  input  logic            clock,
  input  logic            reset,
  input  rv_pkg::instr_u  ir,
  input  logic            zero,
  input  logic            lt,
  input  logic            ltu,
  input  logic            pready,
  output logic            psel,
  output logic            penable,
  output logic            pwrite,
  output logic [1:0]      alu_a_sel,
  output logic            alu_b_sel,
  output rv_pkg::alu_op_e alu_op,
  output logic            pc_sel,
  output logic            pc_target_reg,
  output logic [1:0]      wb_sel,
  output logic            addr_sel,
  output logic            pc_en,
  output logic            ir_en,
  output logic            reg_wr_en,
  output logic            mdr_en
);

  localparam logic [2:0] FETCH_SETUP  = 3'd0;
  localparam logic [2:0] FETCH_ACCESS = 3'd1;
  localparam logic [2:0] DECODE       = 3'd2;
  localparam logic [2:0] EXECUTE      = 3'd3;
  localparam logic [2:0] MEM_SETUP    = 3'd4;
  localparam logic [2:0] MEM_ACCESS   = 3'd5;
  localparam logic [2:0] WRITEBACK    = 3'd6;

  logic [2:0] state;
  logic [2:0] next_state;
  logic [6:0] opcode;
  logic       is_load;
  logic       is_store;
  logic       taken;

  assign opcode   = ir.r.opcode;
  assign is_load  = (opcode == `RV_OP_LOAD);
  assign is_store = (opcode == `RV_OP_STORE);

  // Flags come from rs1 - rs2
  always_comb begin
    case (ir.b.funct3)
      3'b000:  taken = zero;
      3'b001:  taken = !zero;
      3'b100:  taken = lt;
      3'b101:  taken = !lt;
      3'b110:  taken = ltu;
      3'b111:  taken = !ltu;
      default: taken = 1'b0;
    endcase
  end

  // Datapath selects depend on the IR only and hold for the whole instruction
  always_comb begin
    alu_op = rv_pkg::ALU_ADD;
    if (opcode == `RV_OP_BRANCH) begin
      alu_op = rv_pkg::ALU_SUB;
    end else if (opcode == `RV_OP_REG || opcode == `RV_OP_IMM) begin
      case (ir.r.funct3)
        3'b000: begin
          alu_op = (opcode == `RV_OP_REG && ir.r.funct7[5]) ? rv_pkg::ALU_SUB
                                                            : rv_pkg::ALU_ADD;
        end
        3'b001:  alu_op = rv_pkg::ALU_SLL;
        3'b010:  alu_op = rv_pkg::ALU_SLT;
        3'b011:  alu_op = rv_pkg::ALU_SLTU;
        3'b100:  alu_op = rv_pkg::ALU_XOR;
        3'b101:  alu_op = ir.r.funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
        3'b110:  alu_op = rv_pkg::ALU_OR;
        default: alu_op = rv_pkg::ALU_AND;
      endcase
    end
  end

  assign alu_a_sel = (opcode == `RV_OP_LUI)   ? 2'd2 :
                     (opcode == `RV_OP_AUIPC) ? 2'd1 : 2'd0;
  assign alu_b_sel = !(opcode == `RV_OP_REG || opcode == `RV_OP_BRANCH);
  assign wb_sel    = is_load ? 2'd1 :
                     (opcode == `RV_OP_JAL || opcode == `RV_OP_JALR) ? 2'd2 : 2'd0;
  assign pc_target_reg = (opcode == `RV_OP_JALR);

  // Reset parks in EXECUTE with a cleared IR, which falls straight into fetch
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= EXECUTE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    addr_sel   = 1'b0;
    pc_sel     = 1'b0;
    pc_en      = 1'b0;
    ir_en      = 1'b0;
    reg_wr_en  = 1'b0;
    mdr_en     = 1'b0;
    case (state)
      FETCH_SETUP: begin
        psel       = 1'b1;
        next_state = FETCH_ACCESS;
      end
      FETCH_ACCESS: begin
        psel    = 1'b1;
        penable = 1'b1;
        if (pready) begin
          ir_en      = 1'b1;
          pc_en      = 1'b1;
          next_state = DECODE;
        end
      end
      DECODE: begin
        next_state = EXECUTE;
      end
      EXECUTE: begin
        pc_sel = 1'b1;
        case (opcode)
          `RV_OP_BRANCH: begin
            pc_en      = taken;
            next_state = FETCH_SETUP;
          end
          `RV_OP_JAL, `RV_OP_JALR: begin
            pc_en      = 1'b1;
            next_state = WRITEBACK;
          end
          `RV_OP_LOAD, `RV_OP_STORE: begin
            next_state = MEM_SETUP;
          end
          `RV_OP_LUI, `RV_OP_AUIPC, `RV_OP_IMM, `RV_OP_REG: begin
            next_state = WRITEBACK;
          end
          default: begin
            next_state = FETCH_SETUP;
          end
        endcase
      end
      MEM_SETUP: begin
        psel       = 1'b1;
        addr_sel   = 1'b1;
        pwrite     = is_store;
        next_state = MEM_ACCESS;
      end
      MEM_ACCESS: begin
        psel     = 1'b1;
        penable  = 1'b1;
        addr_sel = 1'b1;
        pwrite   = is_store;
        if (pready) begin
          mdr_en     = is_load;
          next_state = is_load ? WRITEBACK : FETCH_SETUP;
        end
      end
      WRITEBACK: begin
        reg_wr_en  = 1'b1;
        next_state = FETCH_SETUP;
      end
      default: begin
        next_state = FETCH_SETUP;
      end
    endcase
  end

endmodule

// File: hw/dataflow.sv
/*
 * RV32I multicycle datapath: PC, IR, register file, immediates, ALU,
 * PC adders and the APB address and write data
 */
`timescale 1ns/1ps
`include "rv_defs.svh"

module dataflow (
  input  logic                clock,
  input  logic                reset,
  input  logic [`RV_XLEN-1:0] prdata,
  output logic [`RV_XLEN-1:0] paddr,
  output logic [`RV_XLEN-1:0] pwdata,
  input  logic [1:0]          alu_a_sel,
  input  logic                alu_b_sel,
  input  rv_pkg::alu_op_e     alu_op,
  input  logic                pc_sel,
  input  logic                pc_target_reg,
  input  logic [1:0]          wb_sel,
  input  logic                addr_sel,
  input  logic                pc_en,
  input  logic                ir_en,
  input  logic                mdr_en,
  input  logic                reg_wr_en,
  output rv_pkg::instr_u      ir,
  output logic                zero,
  output logic                lt,
  output logic                ltu
);

  rv_pkg::instr_u      ir_q;
  logic [`RV_XLEN-1:0] pc_q;
  // Address of the instruction in flight, PC moves on at fetch end
  logic [`RV_XLEN-1:0] pc_old_q;
  logic [`RV_XLEN-1:0] link_q;
  logic [`RV_XLEN-1:0] mdr_q;
  logic [`RV_XLEN-1:0] alu_q;
  logic [4:0]          rs1_addr;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] wb_data;
  logic [`RV_XLEN-1:0] imm;
  logic [`RV_XLEN-1:0] alu_a;
  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] alu_y;
  logic [`RV_XLEN-1:0] pc_plus_4;
  logic [`RV_XLEN-1:0] target_base;
  logic [`RV_XLEN-1:0] target_sum;
  logic [`RV_XLEN-1:0] pc_target;

  // LUI reads x0 so rs1 + imm gives the upper immediate
  assign rs1_addr = ir_q.r.rs1 & {5{ir_q.r.opcode != `RV_OP_LUI}};

  register_file u_register_file (
    .clock   (clock),
    .reset   (reset),
    .wr_en   (reg_wr_en),
    .rs1_addr(rs1_addr),
    .rs2_addr(ir_q.r.rs2),
    .rd_addr (ir_q.r.rd),
    .rd_data (wb_data),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  imm_extender u_imm_extender (
    .ir (ir_q),
    .imm(imm)
  );

  // Operand A: 0 rs1, 1 instruction address, 2 zero
  always_comb begin
    case (alu_a_sel)
      2'd0:    alu_a = rs1_data;
      2'd1:    alu_a = pc_old_q;
      default: alu_a = '0;
    endcase
  end

  assign alu_b = alu_b_sel ? imm : rs2_data;

  alu u_alu (
    .a   (alu_a),
    .b   (alu_b),
    .op  (alu_op),
    .y   (alu_y),
    .zero(zero),
    .lt  (lt),
    .ltu (ltu)
  );

  // Jump and branch target, JALR drops bit 0
  assign target_base = pc_target_reg ? rs1_data : pc_old_q;
  assign target_sum  = target_base + imm;
  assign pc_target   = {target_sum[`RV_XLEN-1:1], target_sum[0] & ~pc_target_reg};
  assign pc_plus_4   = pc_q + `RV_XLEN'd4;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q <= `RV_RESET_PC;
      ir_q <= '0;
    end else begin
      if (pc_en) begin
        pc_q <= pc_sel ? pc_target : pc_plus_4;
      end
      if (ir_en) begin
        ir_q <= prdata;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (ir_en) begin
      pc_old_q <= pc_q;
      link_q   <= pc_plus_4;
    end
    if (mdr_en) begin
      mdr_q <= prdata;
    end
    // Operands hold after EXECUTE, so this stays valid through MEM and WB
    alu_q <= alu_y;
  end

  // Writeback: 0 ALU, 1 load data, 2 link
  always_comb begin
    case (wb_sel)
      2'd0:    wb_data = alu_q;
      2'd1:    wb_data = mdr_q;
      default: wb_data = link_q;
    endcase
  end

  assign paddr  = addr_sel ? alu_q : pc_q;
  assign pwdata = rs2_data;
  assign ir     = ir_q;

endmodule

// File: hw/imm_extender.sv
/*
 * Immediate extender: picks the I, S, B, U or J immediate by opcode
 * and sign-extends it to the data width
 */
`timescale 1ns/1ps
`include "rv_defs.svh"

module imm_extender (
  input  rv_pkg::instr_u      ir,
  output logic [`RV_XLEN-1:0] imm
);

  always_comb begin
    case (ir.r.opcode)
      `RV_OP_IMM, `RV_OP_LOAD, `RV_OP_JALR: begin
        imm = {{20{ir.i.imm12[11]}}, ir.i.imm12};
      end
      `RV_OP_STORE: begin
        imm = {{20{ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
      end
      // Branch offsets are in halfwords, bit 0 always zero
      `RV_OP_BRANCH: begin
        imm = {{20{ir.b.imm12}}, ir.b.imm11, ir.b.imm10_5, ir.b.imm4_1, 1'b0};
      end
      `RV_OP_LUI, `RV_OP_AUIPC: begin
        imm = {ir.u.imm31_12, 12'h000};
      end
      `RV_OP_JAL: begin
        imm = {{12{ir.j.imm20}}, ir.j.imm19_12, ir.j.imm11, ir.j.imm10_1, 1'b0};
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

// File: hw/register_file.sv
/*
 * Integer register file, 32 x 32 bits, x0 reads as zero
 */
`timescale 1ns/1ps
`include "rv_defs.svh"

module register_file (
  input  logic                clock,
  input  logic                reset,
  input  logic                wr_en,
  input  logic [4:0]          rs1_addr,
  input  logic [4:0]          rs2_addr,
  input  logic [4:0]          rd_addr,
  input  logic [`RV_XLEN-1:0] rd_data,
  output logic [`RV_XLEN-1:0] rs1_data,
  output logic [`RV_XLEN-1:0] rs2_data
);

  logic [`RV_XLEN-1:0] regs [0:31];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int n = 0; n < 32; n++) begin
        regs[n] <= '0;
      end
    end else if (wr_en && rd_addr != 5'd0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // Reads are combinational; writeback never shares a cycle with a read
  assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// File: hw/rv_core.sv
/*
 * RV32I multicycle core top: control unit and datapath on one APB master port
 */
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_core (
  input  logic                clock,
  input  logic                reset,
  output logic [`RV_XLEN-1:0] paddr,
  output logic                psel,
  output logic                penable,
  output logic                pwrite,
  output logic [`RV_XLEN-1:0] pwdata,
  input  logic [`RV_XLEN-1:0] prdata,
  input  logic                pready
);

  rv_pkg::instr_u  ir;
  rv_pkg::alu_op_e alu_op;
  logic [1:0]      alu_a_sel;
  logic            alu_b_sel;
  logic            pc_sel;
  logic            pc_target_reg;
  logic [1:0]      wb_sel;
  logic            addr_sel;
  logic            pc_en;
  logic            ir_en;
  logic            reg_wr_en;
  logic            mdr_en;
  logic            zero;
  logic            lt;
  logic            ltu;

  control_unit u_control_unit (
    .clock        (clock),
    .reset        (reset),
    .ir           (ir),
    .zero         (zero),
    .lt           (lt),
    .ltu          (ltu),
    .pready       (pready),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .alu_a_sel    (alu_a_sel),
    .alu_b_sel    (alu_b_sel),
    .alu_op       (alu_op),
    .pc_sel       (pc_sel),
    .pc_target_reg(pc_target_reg),
    .wb_sel       (wb_sel),
    .addr_sel     (addr_sel),
    .pc_en        (pc_en),
    .ir_en        (ir_en),
    .reg_wr_en    (reg_wr_en),
    .mdr_en       (mdr_en)
  );

  dataflow u_dataflow (
    .clock        (clock),
    .reset        (reset),
    .prdata       (prdata),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .alu_a_sel    (alu_a_sel),
    .alu_b_sel    (alu_b_sel),
    .alu_op       (alu_op),
    .pc_sel       (pc_sel),
    .pc_target_reg(pc_target_reg),
    .wb_sel       (wb_sel),
    .addr_sel     (addr_sel),
    .pc_en        (pc_en),
    .ir_en        (ir_en),
    .mdr_en       (mdr_en),
    .reg_wr_en    (reg_wr_en),
    .ir           (ir),
    .zero         (zero),
    .lt           (lt),
    .ltu          (ltu)
  );

endmodule

// File: hw/rv_pkg.sv
/*
 * RV32I core types: instruction word formats and ALU operations
 */
package rv_pkg;

  // One 32-bit instruction word seen through each base format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } instr_u;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

endpackage

// File: include/rv_defs.svh
/*
 * RV32I core constants: data width, reset PC, major opcodes
 * and the word count of the memory behind the APB port
 */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define RV_XLEN      32
`define RV_RESET_PC  32'h0000_0000

// Words of memory on the APB side
`define RV_MEM_WORDS 1024

// Major opcodes, instruction bits 6:0
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011

`endif

// File: sim/core_checker.sv
/*
 * APB protocol and reset assertions, bound to the core top level
 */
`timescale 1ns/1ps

module core_checker (
  input logic        clock,
  input logic        reset,
  input logic        psel,
  input logic        penable,
  input logic        pwrite,
  input logic        pready,
  input logic [31:0] paddr
);

  // A transfer ends only on pready
  assert property (@(posedge clock) disable iff (reset)
    psel && !pready |=> psel)
    else $error("psel dropped before pready");

  // Access phase always follows a setup cycle
  assert property (@(posedge clock) disable iff (reset)
    penable |-> $past(psel))
    else $error("penable without a setup cycle");

  assert property (@(posedge clock) disable iff (reset)
    psel && penable && !pready |=> $stable(paddr) && $stable(pwrite))
    else $error("address or direction changed while waiting");

  assert property (@(posedge clock)
    reset |=> !psel)
    else $error("psel high during reset");

endmodule

// File: sim/core_monitor.sv
/*
 * Store monitor that compares every APB write with the expected stream,
 * flags misaligned transfers and keeps per-test and total counts
 */
`timescale 1ns/1ps

module core_monitor (
  input logic        clock,
  input logic        reset,
  input logic [31:0] paddr,
  input logic        psel,
  input logic        penable,
  input logic        pwrite,
  input logic [31:0] pwdata,
  input logic        pready
);

  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  int          test_errors;
  int          errors;
  int          tests_run;
  int          tests_failed;

  initial begin
    test_errors  = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
  end

  // RV32I result of an ALU operation
  function automatic logic [31:0] ref_alu(string op, logic [31:0] a, logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      "add":   return a + b;
      "sub":   return a - b;
      "sll":   return a << sh;
      "slt":   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      "sltu":  return (a < b) ? 32'd1 : 32'd0;
      "xor":   return a ^ b;
      "srl":   return a >> sh;
      "sra":   return $unsigned($signed(a) >>> sh);
      "or":    return a | b;
      default: return a & b;
    endcase
  endfunction

  // Whether a conditional branch is taken
  function automatic bit ref_branch(string cond, logic [31:0] a, logic [31:0] b);
    case (cond)
      "beq":   return a == b;
      "bne":   return a != b;
      "blt":   return $signed(a) < $signed(b);
      "bge":   return $signed(a) >= $signed(b);
      "bltu":  return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic expect_store(logic [31:0] addr, logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  function automatic int pending_count();
    return exp_addr.size();
  endfunction

  task automatic start_test();
    exp_addr.delete();
    exp_data.delete();
    test_errors = 0;
  endtask

  task automatic finish_test(string name);
    if (exp_addr.size() != 0) begin
      $display("%s: %0d expected stores never happened", name, exp_addr.size());
      test_errors++;
      errors++;
    end
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
      $display("%s: FAILED with %0d errors", name, test_errors);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  task automatic report();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
  endtask

  function automatic int total_errors();
    return errors;
  endfunction

  always @(posedge clock) begin
    logic [31:0] a;
    logic [31:0] d;
    // Word memory ignores the low address bits, so an odd PC would go unseen
    if (!reset && psel && penable && pready && paddr[1:0] != 2'b00) begin
      $display("misaligned APB access to address %h at %0t", paddr, $time);
      test_errors++;
      errors++;
    end
    if (!reset && psel && penable && pready && pwrite) begin
      if (exp_addr.size() == 0) begin
        $display("unexpected store of %h to address %h at %0t", pwdata, paddr, $time);
        test_errors++;
        errors++;
      end else begin
        a = exp_addr.pop_front();
        d = exp_data.pop_front();
        if (paddr != a || pwdata != d) begin
          $display("error %0t: store %h to %h, expected %h to %h",
                   $time, pwdata, paddr, d, a);
          test_errors++;
          errors++;
        end
      end
    end
  end

endmodule

// File: include/tb_defs.svh
/*
 * Testbench constants: test count, watchdog budget and memory map of the test programs
 */
`ifndef TB_DEFS_SVH
`define TB_DEFS_SVH

`define TB_NUM_TESTS    10
`define TB_CYCLES_EACH  400
`define TB_DATA_BASE    32'h0000_0400
`define TB_STORE_BASE   32'h0000_0600

`endif

// File: sim/tb_top.sv
/*
 * Core testbench with clock, reset, APB memory with wait states,
 * test programs and watchdog
 */
`timescale 1ns/1ps
`include "rv_defs.svh"
`include "tb_defs.svh"

module tb_top;

  logic        clock;
  logic        reset;
  logic [31:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;

  logic [31:0] mem [0:`RV_MEM_WORDS-1];
  logic [31:0] rnd [0:15];
  int          seed;
  int          ptr;
  int          wait_left;
  bit          random_waits;

  rv_core uut (
    .clock  (clock),
    .reset  (reset),
    .paddr  (paddr),
    .psel   (psel),
    .penable(penable),
    .pwrite (pwrite),
    .pwdata (pwdata),
    .prdata (prdata),
    .pready (pready)
  );

  core_monitor u_monitor (
    .clock  (clock),
    .reset  (reset),
    .paddr  (paddr),
    .psel   (psel),
    .penable(penable),
    .pwrite (pwrite),
    .pwdata (pwdata),
    .pready (pready)
  );

  bind rv_core core_checker u_checker (
    .clock  (clock),
    .reset  (reset),
    .psel   (psel),
    .penable(penable),
    .pwrite (pwrite),
    .pready (pready),
    .paddr  (paddr)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // APB slave model with a word memory and zero to three wait states
  always @(posedge clock) begin
    if (psel && penable && pready && pwrite) begin
      mem[paddr[11:2]] = pwdata;
    end
    #1;
    if (psel && !penable) begin
      wait_left = random_waits ? ($random(seed) & 3) : 0;
      pready    = 1'b0;
    end else if (psel && penable) begin
      if (wait_left == 0) begin
        pready = 1'b1;
      end else begin
        wait_left--;
        pready = 1'b0;
      end
    end else begin
      pready = 1'b0;
    end
    prdata = mem[paddr[11:2]];
  end

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  // SW rs2, addr(x0)
  function automatic logic [31:0] enc_sw(logic [4:0] rs2, logic [31:0] addr);
    return {addr[11:5], rs2, 5'd0, 3'b010, addr[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_lw(logic [4:0] rd, logic [31:0] addr);
    return enc_i(addr[11:0], 5'd0, 3'b010, rd, 7'b0000011);
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] sext12(logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic string alu_name(int k);
    case (k)
      0: return "add";
      1: return "sub";
      2: return "sll";
      3: return "slt";
      4: return "sltu";
      5: return "xor";
      6: return "srl";
      7: return "sra";
      8: return "or";
      default: return "and";
    endcase
  endfunction

  function automatic logic [2:0] alu_f3(int k);
    case (k)
      0, 1: return 3'd0;
      2: return 3'd1;
      3: return 3'd2;
      4: return 3'd3;
      5: return 3'd4;
      6, 7: return 3'd5;
      8: return 3'd6;
      default: return 3'd7;
    endcase
  endfunction

  task automatic put(logic [31:0] word);
    mem[ptr] = word;
    ptr++;
  endtask

  // Holds the core in reset, clears memory and the expected stream
  task automatic begin_test();
    @(posedge clock);
    #1 reset = 1'b1;
    repeat (10) @(posedge clock);
    for (int i = 0; i < `RV_MEM_WORDS; i++) begin
      mem[i] = 32'h5a00_0000 ^ (i * 32'h0001_0003);
    end
    ptr = 0;
    u_monitor.start_test();
  endtask

  // Parks the core in a self loop, runs the program and waits for its stores
  task automatic run_test(string name);
    int cycles;
    put(enc_j(21'd0, 5'd0));
    cycles = 0;
    #1 reset = 1'b0;
    while (u_monitor.pending_count() > 0 && cycles < `TB_CYCLES_EACH) begin
      @(posedge clock);
      cycles++;
    end
    repeat (20) @(posedge clock);
    u_monitor.finish_test(name);
  endtask

  task automatic test_reg_ops(int pass);
    begin_test();
    mem[`TB_DATA_BASE >> 2]       = rnd[0];
    mem[(`TB_DATA_BASE >> 2) + 1] = rnd[1];
    put(enc_lw(5'd1, `TB_DATA_BASE));
    put(enc_lw(5'd2, `TB_DATA_BASE + 4));
    for (int k = 0; k < 10; k++) begin
      put(enc_r((k == 1 || k == 7) ? 7'h20 : 7'h00, 5'd2, 5'd1, alu_f3(k), 5'd3));
      put(enc_sw(5'd3, `TB_STORE_BASE + 4 * k));
      u_monitor.expect_store(`TB_STORE_BASE + 4 * k,
                             u_monitor.ref_alu(alu_name(k), rnd[0], rnd[1]));
    end
    run_test($sformatf("register ops pass %0d", pass));
  endtask

  task automatic test_imm_ops(int pass);
    logic [11:0] imm;
    logic [31:0] addr;
    int          kinds [7];
    kinds = '{0, 0, 5, 3, 4, 9, 8};
    begin_test();
    mem[`TB_DATA_BASE >> 2] = rnd[2];
    put(enc_lw(5'd1, `TB_DATA_BASE));
    for (int n = 0; n < 7; n++) begin
      imm = rnd[5 + n][11:0];
      // First ADDI negative, second positive
      if (n == 0) begin
        imm[11] = 1'b1;
      end
      if (n == 1) begin
        imm[11] = 1'b0;
      end
      put(enc_i(imm, 5'd1, alu_f3(kinds[n]), 5'd3, 7'b0010011));
      put(enc_sw(5'd3, `TB_STORE_BASE + 4 * n));
      u_monitor.expect_store(`TB_STORE_BASE + 4 * n,
                             u_monitor.ref_alu(alu_name(kinds[n]), rnd[2], sext12(imm)));
    end
    put(enc_i({7'h20, rnd[12][4:0]}, 5'd1, 3'd5, 5'd3, 7'b0010011));
    put(enc_sw(5'd3, `TB_STORE_BASE + 28));
    u_monitor.expect_store(`TB_STORE_BASE + 28,
                           u_monitor.ref_alu("sra", rnd[2], {27'd0, rnd[12][4:0]}));
    put({rnd[13][31:12], 5'd3, 7'b0110111});
    put(enc_sw(5'd3, `TB_STORE_BASE + 32));
    u_monitor.expect_store(`TB_STORE_BASE + 32, {rnd[13][31:12], 12'h000});
    addr = ptr * 4;
    put({rnd[14][31:12], 5'd3, 7'b0010111});
    put(enc_sw(5'd3, `TB_STORE_BASE + 36));
    u_monitor.expect_store(`TB_STORE_BASE + 36, addr + {rnd[14][31:12], 12'h000});
    run_test($sformatf("immediate ops pass %0d", pass));
  endtask

  task automatic test_load(int pass);
    logic [11:0] imm;
    imm = rnd[15][11:0];
    begin_test();
    mem[(`TB_DATA_BASE >> 2) + 2] = rnd[3];
    put(enc_lw(5'd4, `TB_DATA_BASE + 8));
    put(enc_i(imm, 5'd4, 3'd0, 5'd5, 7'b0010011));
    put(enc_sw(5'd5, `TB_STORE_BASE));
    put(enc_sw(5'd4, `TB_STORE_BASE + 4));
    u_monitor.expect_store(`TB_STORE_BASE, u_monitor.ref_alu("add", rnd[3], sext12(imm)));
    u_monitor.expect_store(`TB_STORE_BASE + 4, rnd[3]);
    run_test($sformatf("load and store pass %0d", pass));
  endtask

  task automatic test_branches(int pass);
    string       names [8];
    logic [2:0]  f3s [8];
    logic [4:0]  rs2;
    logic [31:0] b;
    names = '{"beq", "bne", "blt", "bge", "bltu", "bgeu", "beq", "bgeu"};
    f3s   = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7, 3'd0, 3'd7};
    begin_test();
    mem[(`TB_DATA_BASE >> 2) + 3] = rnd[4];
    mem[(`TB_DATA_BASE >> 2) + 4] = rnd[5];
    put(enc_lw(5'd1, `TB_DATA_BASE + 12));
    put(enc_lw(5'd2, `TB_DATA_BASE + 16));
    for (int n = 0; n < 8; n++) begin
      // Last two compare a register with itself
      rs2 = (n < 6) ? 5'd2 : 5'd1;
      b   = (n < 6) ? rnd[5] : rnd[4];
      put(enc_i(12'd1, 5'd0, 3'd0, 5'd6, 7'b0010011));
      put(enc_b(13'd8, rs2, 5'd1, f3s[n]));
      put(enc_i(12'd2, 5'd0, 3'd0, 5'd6, 7'b0010011));
      put(enc_sw(5'd6, `TB_STORE_BASE + 4 * n));
      u_monitor.expect_store(`TB_STORE_BASE + 4 * n,
                             u_monitor.ref_branch(names[n], rnd[4], b) ? 32'd1 : 32'd2);
    end
    run_test($sformatf("branches pass %0d", pass));
  endtask

  task automatic test_jumps(int pass);
    logic [31:0] at;
    begin_test();
    at = ptr * 4;
    put(enc_j(21'd12, 5'd7));
    put(enc_sw(5'd0, `TB_STORE_BASE + 12));
    put(enc_sw(5'd0, `TB_STORE_BASE + 12));
    put(enc_sw(5'd7, `TB_STORE_BASE));
    u_monitor.expect_store(`TB_STORE_BASE, at + 4);
    // Odd target checks that JALR clears bit 0
    at = ptr * 4;
    put(enc_i(at[11:0] + 12'd13, 5'd0, 3'd0, 5'd10, 7'b0010011));
    put(enc_i(12'd0, 5'd10, 3'd0, 5'd11, 7'b1100111));
    put(enc_sw(5'd0, `TB_STORE_BASE + 12));
    put(enc_sw(5'd11, `TB_STORE_BASE + 4));
    put(enc_i(12'h077, 5'd0, 3'd0, 5'd12, 7'b0010011));
    put(enc_sw(5'd12, `TB_STORE_BASE + 8));
    u_monitor.expect_store(`TB_STORE_BASE + 4, at + 8);
    u_monitor.expect_store(`TB_STORE_BASE + 8, 32'h77);
    run_test($sformatf("jumps pass %0d", pass));
  endtask

  initial begin
    reset        = 1'b1;
    pready       = 1'b0;
    prdata       = '0;
    wait_left    = 0;
    random_waits = 1'b0;
    seed         = 32'hb88f_cf34;
    for (int i = 0; i < 16; i++) begin
      rnd[i] = $random(seed);
    end
    repeat (10) @(posedge clock);
    for (int pass = 0; pass < 2; pass++) begin
      random_waits = (pass == 1);
      test_reg_ops(pass);
      test_imm_ops(pass);
      test_load(pass);
      test_branches(pass);
      test_jumps(pass);
    end
    u_monitor.report();
    if (u_monitor.total_errors() == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog over the budget of all tests
  initial begin
    #(`TB_NUM_TESTS * `TB_CYCLES_EACH * 40);
    $display("simulation timed out before all tests finished");
    $display("test failed");
    $finish;
  end

endmodule

// File: tb.f
+incdir+include
hw/rv_pkg.sv
hw/imm_extender.sv
hw/register_file.sv
hw/alu.sv
hw/dataflow.sv
hw/control_unit.sv
hw/rv_core.sv
sim/core_checker.sv
sim/core_monitor.sv
sim/tb_top.sv
